/* src.f */
ddr_cmd_pkg.sv
ddr_geom_pkg.sv
request_decoder.sv
command_sequencer.sv
data_path.sv
ddr_memory_controller.sv
ddr_props.sv
tb_ddr_memory_controller.sv

/* Makefile */
TOP = tb_ddr_memory_controller

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for a pass"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_ddr_memory_controller.sv */
module tb_ddr_memory_controller;

  localparam int CAS_LAT     = ddr_cmd_pkg::DEF_CAS_LAT;
  localparam int INIT_CYCLES = ddr_cmd_pkg::DEF_INIT_CYCLES;
  localparam int NUM_XFER    = 40;
  localparam int TIMEOUT     = NUM_XFER * 30 + INIT_CYCLES + 20; // worst access about 30 cycles

  logic                  clk_n;
  logic                  rst_n;
  logic                  refresh_strobe;
  logic [1:0]            req;  // [0] rand, [1] bulk
  logic [1:0]            we;
  logic [3:0]            be    [2];
  logic [25:0]           addr  [2];
  logic [31:0]           wdata [2];
  logic [15:0]           dq_in = '0;
  wire  [1:0]            ack;
  wire  [31:0]           dataout;
  logic                  cke;
  ddr_cmd_pkg::mem_cmd_e command;
  logic [13:0]           address;
  logic [2:0]            bank;
  logic [15:0]           dq_out;
  logic                  dq_oe;
  logic                  udm;
  logic                  ldm;

  int          seed;
  int          cycle_cnt  = 0;
  int          init_stage = 0; // 3 once precharge, mode load and refresh are seen
  int          refreshes  = 0;
  int          data_errs  = 0;
  int          proto_errs = 0;
  int          acks_seen  = 0;
  int          ack_rank   [2]; // order of the latest ack per port
  int          key;
  int          wr_key;
  logic        wr_hi      = 1'b0;
  logic [7:0]  mopen      = '0;
  logic [13:0] mrow       [8];
  logic [15:0] mem        [int];
  logic [31:0] sb         [int];
  logic [15:0] slot_data  [16]; // read beats by cycle
  logic [15:0] slot_vld   = '0;
  logic [25:0] list       [6];
  logic [25:0] pair_a     [4];
  logic [25:0] pair_b     [4];

  ddr_memory_controller #(
    .T_RCD(ddr_cmd_pkg::DEF_T_RCD), .T_RP(ddr_cmd_pkg::DEF_T_RP),
    .T_RFC(ddr_cmd_pkg::DEF_T_RFC), .T_MRD(ddr_cmd_pkg::DEF_T_MRD),
    .CAS_LAT(CAS_LAT), .INIT_CYCLES(INIT_CYCLES)
  ) dut (
    .clk_n, .rst_n, .refresh_strobe,
    .rand_req(req[0]), .rand_req_we(we[0]), .rand_req_we_array(be[0]),
    .rand_req_address(addr[0]), .rand_req_datain(wdata[0]),
    .bulk_req(req[1]), .bulk_req_we(we[1]), .bulk_req_we_array(be[1]),
    .bulk_req_address(addr[1]), .bulk_req_datain(wdata[1]),
    .dq_in, .cke, .command, .address, .bank, .dq_out, .dq_oe, .udm, .ldm,
    .rand_req_ack(ack[0]), .bulk_req_ack(ack[1]), .user_req_dataout(dataout)
  );

  initial begin
    clk_n = 1'b0;
    forever #20 clk_n = ~clk_n;
  end

  function automatic logic [15:0] fill_value(input int k);
    return k[15:0] ^ {5'b0, k[26:16]} ^ 16'h5a3c;
  endfunction

  function automatic logic [15:0] read_half(input int k);
    return mem.exists(k) ? mem[k] : fill_value(k);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                              input logic [3:0] m);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (m[i]) res[i*8 +: 8] = d[i*8 +: 8];
    end
    return res;
  endfunction

  // bank, row 0..3, column bit 8 kept clear for the rand port
  function automatic logic [25:0] pick_addr(input logic [31:0] r);
    return {r[2:0], 12'd0, r[4:3], 1'b0, r[12:5]};
  endfunction

  task automatic protocol_check(input bit ok, input string msg);
    assert (ok) else begin
      proto_errs++;
      $display("Memory model: %s at time %0t", msg, $time);
    end
  endtask

  // every contended pair follows a rand grant, so bulk goes first
  task automatic check_grant_order();
    assert (ack_rank[1] < ack_rank[0]) else begin
      data_errs++;
      $display("Error at %0t: rand acknowledged ahead of bulk under contention", $time);
    end
  endtask

  task automatic store_half(input int k, input logic [15:0] d, input logic [1:0] dm);
    logic [15:0] cur;
    cur = read_half(k);
    if (!dm[0]) cur[7:0] = d[7:0];
    if (!dm[1]) cur[15:8] = d[15:8];
    mem[k] = cur;
  endtask

  task automatic user_access(input bit p, input logic w, input logic [3:0] m,
                             input logic [25:0] a, input logic [31:0] d);
    logic [31:0] want;
    @(posedge clk_n);
    #5;
    req[p]   = 1'b1;
    we[p]    = w;
    be[p]    = m;
    addr[p]  = a;
    wdata[p] = d;
    if (w) sb[a] = merge_bytes(sb.exists(a) ? sb[a] : 32'h0, d, m);
    @(posedge clk_n);
    while (!ack[p]) @(posedge clk_n);
    ack_rank[p] = acks_seen;
    acks_seen++;
    if (!w) begin
      want = sb.exists(a) ? sb[a] : 32'h0;
      assert (dataout === want) else begin
        data_errs++;
        $display("Error at %0t: port %0d read %h got %h expected %h", $time, p, a, dataout, want);
      end
    end
    #5;
    req[p] = 1'b0;
  endtask

  initial begin
    wait (cycle_cnt > TIMEOUT);
    $display("Timeout after %0d cycles, a request was never acknowledged", cycle_cnt);
    $display("Simulation FAILED");
    $finish;
  end

  // memory model, sees the pins as they were during the cycle just ended
  always @(posedge clk_n) begin
    cycle_cnt = cycle_cnt + 1;
    if (rst_n) begin
      protocol_check(!(|ack) || init_stage == 3, "acknowledge before initialization finished");
      protocol_check(cke || command == ddr_cmd_pkg::CMD_NOP, "command issued with cke low");
      if (wr_hi) begin
        protocol_check(dq_oe, "dq_oe low on second write beat");
        store_half(wr_key + 1, dq_out, {udm, ldm});
        wr_hi = 1'b0;
      end
      case (command)
        ddr_cmd_pkg::CMD_PRECHARGE: begin
          if (init_stage == 0) begin
            protocol_check(address[10], "first precharge does not close all banks");
            init_stage = 1;
          end
          if (address[10]) mopen = '0;
          else mopen[bank] = 1'b0;
        end
        ddr_cmd_pkg::CMD_LOAD_MODE: begin
          protocol_check(init_stage == 1 && address[6:4] == 3'(CAS_LAT),
                         "mode load out of order or with wrong CAS latency");
          init_stage = 2;
        end
        ddr_cmd_pkg::CMD_REFRESH: begin
          protocol_check(mopen == '0 && init_stage >= 2, "refresh with a bank open or too early");
          if (init_stage == 2) init_stage = 3;
          else refreshes++;
        end
        ddr_cmd_pkg::CMD_ACTIVE: begin
          protocol_check(init_stage == 3 && !mopen[bank], "activate early or on an open bank");
          mopen[bank] = 1'b1;
          mrow[bank]  = address;
        end
        ddr_cmd_pkg::CMD_READ, ddr_cmd_pkg::CMD_WRITE: begin
          protocol_check(mopen[bank] && !address[10], "read or write to a closed bank");
          key = int'({bank, mrow[bank], address[9:0]});
          if (command == ddr_cmd_pkg::CMD_WRITE) begin
            protocol_check(dq_oe, "dq_oe low on first write beat");
            store_half(key, dq_out, {udm, ldm});
            wr_hi  = 1'b1;
            wr_key = key;
          end else begin
            slot_data[4'(cycle_cnt + CAS_LAT - 1)] = read_half(key);
            slot_data[4'(cycle_cnt + CAS_LAT)]     = read_half(key + 1);
            slot_vld[4'(cycle_cnt + CAS_LAT - 1)]  = 1'b1;
            slot_vld[4'(cycle_cnt + CAS_LAT)]      = 1'b1;
          end
        end
        default: ;
      endcase
    end
    #5;
    dq_in = slot_vld[4'(cycle_cnt)] ? slot_data[4'(cycle_cnt)] : 16'h0;
    slot_vld[4'(cycle_cnt)] = 1'b0;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] d0;
    logic [31:0] d1;
    seed           = 8915;
    rst_n          = 1'b0;
    refresh_strobe = 1'b0;
    req            = '0;
    we             = '0;
    for (int i = 0; i < 2; i++) begin
      be[i]    = '0;
      addr[i]  = '0;
      wdata[i] = '0;
    end
    repeat (2) @(posedge clk_n);
    #5;
    rst_n = 1'b1;

    // first request waits out the init sequence
    for (int i = 0; i < 6; i++) begin
      r       = $random(seed);
      list[i] = pick_addr(r);
      d0      = $random(seed);
      user_access(1'b0, 1'b1, 4'hf, list[i], d0);
    end
    for (int i = 0; i < 6; i++) user_access(1'b0, 1'b0, 4'h0, list[i], 32'h0);

    // partial byte enables on words already written
    for (int i = 0; i < 3; i++) begin
      r  = $random(seed);
      d0 = $random(seed);
      user_access(1'b0, 1'b1, r[3:0], list[i], d0);
    end
    for (int i = 0; i < 3; i++) user_access(1'b0, 1'b0, 4'h0, list[i], 32'h0);

    // both ports together, bulk one bank up; the reads overlap
    for (int i = 0; i < 4; i++) begin
      r         = $random(seed);
      pair_a[i] = pick_addr(r);
      pair_b[i] = {pair_a[i][25:23] + 3'd1, pair_a[i][22:9], 1'b1, pair_a[i][7:0]};
      d0        = $random(seed);
      d1        = $random(seed);
      fork
        user_access(1'b0, 1'b1, 4'hf, pair_a[i], d0);
        user_access(1'b1, 1'b1, 4'hf, pair_b[i], d1);
      join
      check_grant_order();
    end
    for (int i = 0; i < 4; i++) begin
      fork
        user_access(1'b0, 1'b0, 4'h0, pair_a[i], 32'h0);
        user_access(1'b1, 1'b0, 4'h0, pair_b[i], 32'h0);
      join
      check_grant_order();
    end

    fork
      repeat (3) begin
        repeat (12) @(posedge clk_n);
        #5;
        refresh_strobe = 1'b1;
        @(posedge clk_n);
        #5;
        refresh_strobe = 1'b0;
      end
      begin
        for (int i = 3; i < 6; i++) user_access(1'b0, 1'b1, 4'hf, list[i], $random(seed));
        for (int i = 3; i < 6; i++) user_access(1'b0, 1'b0, 4'h0, list[i], 32'h0);
      end
    join
    protocol_check(refreshes > 0, "no refresh issued after refresh_strobe");
    protocol_check(init_stage == 3, "initialization sequence never completed");

    repeat (4) @(posedge clk_n);
    $display("errors: data %0d, protocol %0d, assertions %0d",
             data_errs, proto_errs, dut.props.fail_total);
    if (data_errs + proto_errs + dut.props.fail_total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* ddr_props.sv */
module ddr_props #(
  parameter int T_RCD       = 2,
  parameter int T_RFC       = 8,
  parameter int INIT_CYCLES = 50
) (
  input logic                            clk_n,
  input logic                            rst_n,
  input logic                            rand_req,
  input logic                            bulk_req,
  input logic                            rand_req_ack,
  input logic                            bulk_req_ack,
  input logic                            cke,
  input ddr_cmd_pkg::mem_cmd_e           command,
  input logic [ddr_geom_pkg::BANK_W-1:0] bank
);

  int act_age [ddr_geom_pkg::NUM_BANKS]; // cycles since ACTIVE per bank
  int ref_age;
  int since_rst;
  int rand_fail = 0;
  int bulk_fail = 0;
  int rcd_fail  = 0;
  int rfc_fail  = 0;
  int cke_fail  = 0;
  int fail_total;

  assign fail_total = rand_fail + bulk_fail + rcd_fail + rfc_fail + cke_fail;

  always_ff @(posedge clk_n or negedge rst_n) begin
    if (!rst_n) begin
      since_rst <= 0;
      ref_age   <= 1000;
      for (int b = 0; b < ddr_geom_pkg::NUM_BANKS; b++) act_age[b] <= 1000;
    end else begin
      if (since_rst < 1000) since_rst <= since_rst + 1;
      if (command == ddr_cmd_pkg::CMD_REFRESH) ref_age <= 1;
      else if (ref_age < 1000) ref_age <= ref_age + 1;
      for (int b = 0; b < ddr_geom_pkg::NUM_BANKS; b++) begin
        if (command == ddr_cmd_pkg::CMD_ACTIVE && bank == 3'(b)) act_age[b] <= 1;
        else if (act_age[b] < 1000) act_age[b] <= act_age[b] + 1;
      end
    end
  end

  rand_ack_once: assert property (@(posedge clk_n) disable iff (!rst_n)
    rand_req_ack |-> rand_req ##1 !rand_req_ack)
    else begin
      rand_fail = rand_fail + 1;
      $error("rand ack longer than a cycle or without req");
    end

  bulk_ack_once: assert property (@(posedge clk_n) disable iff (!rst_n)
    bulk_req_ack |-> bulk_req ##1 !bulk_req_ack)
    else begin
      bulk_fail = bulk_fail + 1;
      $error("bulk ack longer than a cycle or without req");
    end

  act_to_rw: assert property (@(posedge clk_n) disable iff (!rst_n)
    (command == ddr_cmd_pkg::CMD_READ || command == ddr_cmd_pkg::CMD_WRITE)
      |-> act_age[bank] >= T_RCD)
    else begin
      rcd_fail = rcd_fail + 1;
      $error("read or write sooner than tRCD after activate");
    end

  ref_quiet: assert property (@(posedge clk_n) disable iff (!rst_n)
    command != ddr_cmd_pkg::CMD_NOP |-> ref_age >= T_RFC)
    else begin
      rfc_fail = rfc_fail + 1;
      $error("command inside tRFC after refresh");
    end

  cke_low_init: assert property (@(posedge clk_n) disable iff (!rst_n)
    since_rst < INIT_CYCLES |-> !cke)
    else begin
      cke_fail = cke_fail + 1;
      $error("cke high before the init wait ended");
    end

endmodule

bind ddr_memory_controller ddr_props #(
  .T_RCD(T_RCD), .T_RFC(T_RFC), .INIT_CYCLES(INIT_CYCLES)
) props (
  .clk_n(clk_n), .rst_n(rst_n),
  .rand_req(rand_req), .bulk_req(bulk_req),
  .rand_req_ack(rand_req_ack), .bulk_req_ack(bulk_req_ack),
  .cke(cke), .command(command), .bank(bank)
);

/* ddr_memory_controller.sv */
module ddr_memory_controller #(
  parameter int T_RCD       = ddr_cmd_pkg::DEF_T_RCD,
  parameter int T_RP        = ddr_cmd_pkg::DEF_T_RP,
  parameter int T_RFC       = ddr_cmd_pkg::DEF_T_RFC,
  parameter int T_MRD       = ddr_cmd_pkg::DEF_T_MRD,
  parameter int CAS_LAT     = ddr_cmd_pkg::DEF_CAS_LAT,
  parameter int INIT_CYCLES = ddr_cmd_pkg::DEF_INIT_CYCLES
) (
  input  logic                                  clk_n,
  input  logic                                  rst_n,
  input  logic                                  refresh_strobe,
  input  logic                                  rand_req,
  input  logic                                  rand_req_we,
  input  logic [ddr_geom_pkg::BE_W-1:0]         rand_req_we_array,
  input  logic [ddr_geom_pkg::USER_ADDR_W-1:0]  rand_req_address,
  input  logic [ddr_geom_pkg::USER_DATA_W-1:0]  rand_req_datain,
  input  logic                                  bulk_req,
  input  logic                                  bulk_req_we,
  input  logic [ddr_geom_pkg::BE_W-1:0]         bulk_req_we_array,
  input  logic [ddr_geom_pkg::USER_ADDR_W-1:0]  bulk_req_address,
  input  logic [ddr_geom_pkg::USER_DATA_W-1:0]  bulk_req_datain,
  input  logic [ddr_geom_pkg::DQ_W-1:0]         dq_in,
  output logic                                  cke,
  output ddr_cmd_pkg::mem_cmd_e                 command,
  output logic [ddr_geom_pkg::ROW_W-1:0]        address,
  output logic [ddr_geom_pkg::BANK_W-1:0]       bank,
  output logic [ddr_geom_pkg::DQ_W-1:0]         dq_out,
  output logic                                  dq_oe,
  output logic                                  udm,
  output logic                                  ldm,
  output logic                                  rand_req_ack,
  output logic                                  bulk_req_ack,
  output logic [ddr_geom_pkg::USER_DATA_W-1:0]  user_req_dataout
);

  logic                              acc_valid;
  logic                              acc_we;
  logic [ddr_geom_pkg::BANK_W-1:0]   acc_bank;
  logic [ddr_geom_pkg::ROW_W-1:0]    acc_row;
  logic [ddr_geom_pkg::COL_W-1:0]    acc_col;
  ddr_cmd_pkg::row_class_e           acc_class;
  logic                              acc_port;
  logic                              acc_take;
  logic                              row_opened;
  logic [ddr_geom_pkg::BANK_W-1:0]   opened_bank;
  logic [ddr_geom_pkg::ROW_W-1:0]    opened_row;
  logic                              bank_closed;
  logic [ddr_geom_pkg::BANK_W-1:0]   closed_bank;
  logic                              all_closed;
  logic                              rw_start;
  logic                              rw_we;
  logic                              rw_port;
  logic [ddr_geom_pkg::BE_W-1:0]     rw_we_array;
  logic                              dp_busy;

  request_decoder decoder (
    .clk_n, .rst_n,
    .rand_req, .rand_req_we, .rand_req_address,
    .bulk_req, .bulk_req_we, .bulk_req_address,
    .acc_take, .row_opened, .opened_bank, .opened_row,
    .bank_closed, .closed_bank, .all_closed,
    .acc_valid, .acc_we, .acc_bank, .acc_row, .acc_col, .acc_class, .acc_port
  );

  command_sequencer #(
    .T_RCD(T_RCD), .T_RP(T_RP), .T_RFC(T_RFC), .T_MRD(T_MRD),
    .CAS_LAT(CAS_LAT), .INIT_CYCLES(INIT_CYCLES)
  ) sequencer (
    .clk_n, .rst_n, .refresh_strobe,
    .acc_valid, .acc_we, .acc_bank, .acc_row, .acc_col, .acc_class, .acc_port,
    .rand_req_we_array, .bulk_req_we_array, .dp_busy,
    .cke, .command, .address, .bank, .acc_take,
    .row_opened, .opened_bank, .opened_row, .bank_closed, .closed_bank, .all_closed,
    .rw_start, .rw_we, .rw_port, .rw_we_array
  );

  data_path #(
    .CAS_LAT(CAS_LAT)
  ) datapath (
    .clk_n, .rst_n,
    .rw_start, .rw_we, .rw_port, .rw_we_array,
    .rand_req_datain, .bulk_req_datain, .dq_in,
    .dq_out, .dq_oe, .udm, .ldm, .user_req_dataout,
    .rand_req_ack, .bulk_req_ack, .dp_busy
  );

endmodule

/* data_path.sv */
module data_path #(
  parameter int CAS_LAT = 3
) (
  input  logic                                  clk_n,
  input  logic                                  rst_n,
  input  logic                                  rw_start,
  input  logic                                  rw_we,
  input  logic                                  rw_port,
  input  logic [ddr_geom_pkg::BE_W-1:0]         rw_we_array,
  input  logic [ddr_geom_pkg::USER_DATA_W-1:0]  rand_req_datain,
  input  logic [ddr_geom_pkg::USER_DATA_W-1:0]  bulk_req_datain,
  input  logic [ddr_geom_pkg::DQ_W-1:0]         dq_in,
  output logic [ddr_geom_pkg::DQ_W-1:0]         dq_out,
  output logic                                  dq_oe,
  output logic                                  udm,
  output logic                                  ldm,
  output logic [ddr_geom_pkg::USER_DATA_W-1:0]  user_req_dataout,
  output logic                                  rand_req_ack,
  output logic                                  bulk_req_ack,
  output logic                                  dp_busy
);

  logic                                  wr_start;
  logic [ddr_geom_pkg::USER_DATA_W-1:0]  wr_word;
  logic                                  beat2;
  logic [ddr_geom_pkg::DQ_W-1:0]         hi_data;
  logic [1:0]                            hi_mask; // {udm, ldm}
  logic [CAS_LAT:0]                      rd_vld;  // read tags, stage k = k+1 cycles old
  logic [CAS_LAT:0]                      rd_port;
  logic [ddr_geom_pkg::DQ_W-1:0]         rd_lo;
  logic                                  rd_ack_rand;
  logic                                  rd_ack_bulk;

  assign wr_start = rw_start && rw_we;
  assign wr_word  = rw_port ? bulk_req_datain : rand_req_datain;

  assign dq_oe  = wr_start || beat2;
  assign dq_out = wr_start ? wr_word[ddr_geom_pkg::DQ_W-1:0] : hi_data;
  assign ldm    = wr_start ? !rw_we_array[0] : (!beat2 || hi_mask[0]);
  assign udm    = wr_start ? !rw_we_array[1] : (!beat2 || hi_mask[1]);

  assign dp_busy      = (rw_start && !rw_we) || (|rd_vld);
  assign rand_req_ack = (wr_start && !rw_port) || rd_ack_rand; // write acks with the command
  assign bulk_req_ack = (wr_start && rw_port) || rd_ack_bulk;

  always_ff @(posedge clk_n or negedge rst_n) begin
    if (!rst_n) begin
      beat2       <= 1'b0;
      rd_vld      <= '0;
      rd_ack_rand <= 1'b0;
      rd_ack_bulk <= 1'b0;
    end else begin
      beat2       <= wr_start;
      rd_vld      <= {rd_vld[CAS_LAT-1:0], rw_start && !rw_we};
      rd_ack_rand <= rd_vld[CAS_LAT] && !rd_port[CAS_LAT];
      rd_ack_bulk <= rd_vld[CAS_LAT] && rd_port[CAS_LAT];
    end
  end

  always_ff @(posedge clk_n) begin
    rd_port <= {rd_port[CAS_LAT-1:0], rw_port};
    if (wr_start) begin
      hi_data <= wr_word[ddr_geom_pkg::USER_DATA_W-1:ddr_geom_pkg::DQ_W];
      hi_mask <= ~rw_we_array[3:2];
    end
    if (rd_vld[CAS_LAT-1]) rd_lo <= dq_in; // first beat
    if (rd_vld[CAS_LAT])   user_req_dataout <= {dq_in, rd_lo};
  end

endmodule

/* command_sequencer.sv */
module command_sequencer #(
  parameter int T_RCD       = 2,
  parameter int T_RP        = 2,
  parameter int T_RFC       = 8,
  parameter int T_MRD       = 2,
  parameter int CAS_LAT     = 3,
  parameter int INIT_CYCLES = 50
) (
  input  logic                                clk_n,
  input  logic                                rst_n,
  input  logic                                refresh_strobe,
  input  logic                                acc_valid,
  input  logic                                acc_we,
  input  logic [ddr_geom_pkg::BANK_W-1:0]     acc_bank,
  input  logic [ddr_geom_pkg::ROW_W-1:0]      acc_row,
  input  logic [ddr_geom_pkg::COL_W-1:0]      acc_col,
  input  ddr_cmd_pkg::row_class_e             acc_class,
  input  logic                                acc_port,
  input  logic [ddr_geom_pkg::BE_W-1:0]       rand_req_we_array,
  input  logic [ddr_geom_pkg::BE_W-1:0]       bulk_req_we_array,
  input  logic                                dp_busy,
  output logic                                cke,
  output ddr_cmd_pkg::mem_cmd_e               command,
  output logic [ddr_geom_pkg::ROW_W-1:0]      address,
  output logic [ddr_geom_pkg::BANK_W-1:0]     bank,
  output logic                                acc_take,
  output logic                                row_opened,
  output logic [ddr_geom_pkg::BANK_W-1:0]     opened_bank,
  output logic [ddr_geom_pkg::ROW_W-1:0]      opened_row,
  output logic                                bank_closed,
  output logic [ddr_geom_pkg::BANK_W-1:0]     closed_bank,
  output logic                                all_closed,
  output logic                                rw_start,
  output logic                                rw_we,
  output logic                                rw_port,
  output logic [ddr_geom_pkg::BE_W-1:0]       rw_we_array
);

  localparam int CNT_W = 16;
  localparam logic [ddr_geom_pkg::ROW_W-1:0] ADDR_ALL =
    ddr_geom_pkg::ROW_W'(1) << ddr_geom_pkg::AP_BIT;

  ddr_cmd_pkg::seq_state_e               state;
  logic [CNT_W-1:0]                      cnt;
  logic                                  ref_pend;
  logic                                  idle_ready;
  logic                                  cur_we;
  logic                                  cur_port;
  logic [ddr_geom_pkg::BANK_W-1:0]       cur_bank;
  logic [ddr_geom_pkg::ROW_W-1:0]        cur_row;
  logic [ddr_geom_pkg::COL_W-1:0]        cur_col;
  logic [ddr_geom_pkg::BE_W-1:0]         cur_we_array;

  assign idle_ready = (state == ddr_cmd_pkg::ST_IDLE) && (cnt == '0);
  // pending refresh blocks new accesses, a write waits for reads to drain
  assign acc_take   = idle_ready && !ref_pend && acc_valid && !(acc_we && dp_busy);

  // stable from the take until the next take
  assign opened_bank = cur_bank;
  assign opened_row  = cur_row;
  assign closed_bank = cur_bank;
  assign rw_we       = cur_we;
  assign rw_port     = cur_port;
  assign rw_we_array = cur_we_array;

  always_ff @(posedge clk_n) begin
    if (acc_take) begin
      cur_we       <= acc_we;
      cur_port     <= acc_port;
      cur_bank     <= acc_bank;
      cur_row      <= acc_row;
      cur_col      <= acc_col;
      cur_we_array <= acc_port ? bulk_req_we_array : rand_req_we_array;
    end
  end

  always_ff @(posedge clk_n or negedge rst_n) begin
    if (!rst_n) begin
      state       <= ddr_cmd_pkg::ST_INIT_WAIT;
      cnt         <= CNT_W'(INIT_CYCLES - 1);
      cke         <= 1'b0;
      command     <= ddr_cmd_pkg::CMD_NOP;
      address     <= '0;
      bank        <= '0;
      ref_pend    <= 1'b0;
      row_opened  <= 1'b0;
      bank_closed <= 1'b0;
      all_closed  <= 1'b0;
      rw_start    <= 1'b0;
    end else begin
      command     <= ddr_cmd_pkg::CMD_NOP;
      row_opened  <= 1'b0;
      bank_closed <= 1'b0;
      all_closed  <= 1'b0;
      rw_start    <= 1'b0;
      if (refresh_strobe) ref_pend <= 1'b1;
      if (cnt != '0) begin
        cnt <= cnt - 1'b1; // timing gap
      end else begin
        case (state)
          ddr_cmd_pkg::ST_INIT_WAIT: begin
            cke   <= 1'b1;
            state <= ddr_cmd_pkg::ST_INIT_PRE;
          end
          ddr_cmd_pkg::ST_INIT_PRE, ddr_cmd_pkg::ST_REF_PRE: begin
            command    <= ddr_cmd_pkg::CMD_PRECHARGE;
            address    <= ADDR_ALL;
            all_closed <= 1'b1;
            cnt        <= CNT_W'(T_RP - 1);
            if (state == ddr_cmd_pkg::ST_INIT_PRE) state <= ddr_cmd_pkg::ST_INIT_MODE;
            else                                   state <= ddr_cmd_pkg::ST_REF;
          end
          ddr_cmd_pkg::ST_INIT_MODE: begin
            command <= ddr_cmd_pkg::CMD_LOAD_MODE;
            address <= ddr_geom_pkg::ROW_W'(CAS_LAT << 4); // cas latency field
            bank    <= '0;
            cnt     <= CNT_W'(T_MRD - 1);
            state   <= ddr_cmd_pkg::ST_INIT_REF;
          end
          ddr_cmd_pkg::ST_INIT_REF, ddr_cmd_pkg::ST_REF: begin
            command  <= ddr_cmd_pkg::CMD_REFRESH;
            ref_pend <= refresh_strobe;
            cnt      <= CNT_W'(T_RFC - 1);
            state    <= ddr_cmd_pkg::ST_IDLE;
          end
          ddr_cmd_pkg::ST_IDLE: begin
            if (ref_pend && !dp_busy) begin
              state <= ddr_cmd_pkg::ST_REF_PRE;
            end else if (acc_take) begin
              case (acc_class)
                ddr_cmd_pkg::RC_HIT:  state <= ddr_cmd_pkg::ST_RW;
                ddr_cmd_pkg::RC_MISS: state <= ddr_cmd_pkg::ST_PRE;
                default:              state <= ddr_cmd_pkg::ST_ACT;
              endcase
            end
          end
          ddr_cmd_pkg::ST_PRE: begin
            command     <= ddr_cmd_pkg::CMD_PRECHARGE;
            address     <= '0; // this bank only
            bank        <= cur_bank;
            bank_closed <= 1'b1;
            cnt         <= CNT_W'(T_RP - 1);
            state       <= ddr_cmd_pkg::ST_ACT;
          end
          ddr_cmd_pkg::ST_ACT: begin
            command    <= ddr_cmd_pkg::CMD_ACTIVE;
            address    <= cur_row;
            bank       <= cur_bank;
            row_opened <= 1'b1;
            cnt        <= CNT_W'(T_RCD - 1);
            state      <= ddr_cmd_pkg::ST_RW;
          end
          ddr_cmd_pkg::ST_RW: begin
            if (cur_we) command <= ddr_cmd_pkg::CMD_WRITE;
            else        command <= ddr_cmd_pkg::CMD_READ;
            address  <= ddr_geom_pkg::ROW_W'({cur_col, 1'b0}); // two beats per word
            bank     <= cur_bank;
            rw_start <= 1'b1;
            state    <= ddr_cmd_pkg::ST_IDLE;
          end
          default: state <= ddr_cmd_pkg::ST_IDLE;
        endcase
      end
    end
  end

endmodule

/* request_decoder.sv */
module request_decoder (
  input  logic                                  clk_n,
  input  logic                                  rst_n,
  input  logic                                  rand_req,
  input  logic                                  rand_req_we,
  input  logic [ddr_geom_pkg::USER_ADDR_W-1:0]  rand_req_address,
  input  logic                                  bulk_req,
  input  logic                                  bulk_req_we,
  input  logic [ddr_geom_pkg::USER_ADDR_W-1:0]  bulk_req_address,
  input  logic                                  acc_take,
  input  logic                                  row_opened,
  input  logic [ddr_geom_pkg::BANK_W-1:0]       opened_bank,
  input  logic [ddr_geom_pkg::ROW_W-1:0]        opened_row,
  input  logic                                  bank_closed,
  input  logic [ddr_geom_pkg::BANK_W-1:0]       closed_bank,
  input  logic                                  all_closed,
  output logic                                  acc_valid,
  output logic                                  acc_we,
  output logic [ddr_geom_pkg::BANK_W-1:0]       acc_bank,
  output logic [ddr_geom_pkg::ROW_W-1:0]        acc_row,
  output logic [ddr_geom_pkg::COL_W-1:0]        acc_col,
  output ddr_cmd_pkg::row_class_e               acc_class,
  output logic                                  acc_port
);

  logic                                  rand_busy;
  logic                                  bulk_busy;
  logic                                  last_bulk;
  logic                                  rand_ok;
  logic                                  bulk_ok;
  logic                                  pick_bulk;
  logic                                  load;
  logic [ddr_geom_pkg::USER_ADDR_W-1:0]  pick_addr;
  logic [ddr_geom_pkg::NUM_BANKS-1:0]    open_vld;
  logic [ddr_geom_pkg::ROW_W-1:0]        open_row [ddr_geom_pkg::NUM_BANKS];

  assign rand_ok   = rand_req && !rand_busy;
  assign bulk_ok   = bulk_req && !bulk_busy;
  assign pick_bulk = bulk_ok && (!last_bulk || !rand_ok); // alternate under contention
  assign load      = (!acc_valid || acc_take) && (rand_ok || bulk_ok);
  assign pick_addr = pick_bulk ? bulk_req_address : rand_req_address;

  // a granted port is re-armed only once its req drops after the ack
  always_ff @(posedge clk_n or negedge rst_n) begin
    if (!rst_n) begin
      acc_valid <= 1'b0;
      last_bulk <= 1'b0;
      rand_busy <= 1'b0;
      bulk_busy <= 1'b0;
    end else begin
      if (load) begin
        acc_valid <= 1'b1;
        last_bulk <= pick_bulk;
      end else if (acc_take) begin
        acc_valid <= 1'b0;
      end
      if (load && !pick_bulk) rand_busy <= 1'b1;
      else if (!rand_req)     rand_busy <= 1'b0;
      if (load && pick_bulk)  bulk_busy <= 1'b1;
      else if (!bulk_req)     bulk_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk_n) begin
    if (load) begin
      acc_we   <= pick_bulk ? bulk_req_we : rand_req_we;
      acc_port <= pick_bulk;
      acc_bank <= pick_addr[ddr_geom_pkg::BANK_LSB +: ddr_geom_pkg::BANK_W];
      acc_row  <= pick_addr[ddr_geom_pkg::ROW_LSB +: ddr_geom_pkg::ROW_W];
      acc_col  <= pick_addr[ddr_geom_pkg::COL_LSB +: ddr_geom_pkg::COL_W];
    end
  end

  // open row table
  always_ff @(posedge clk_n or negedge rst_n) begin
    if (!rst_n) begin
      open_vld <= '0;
    end else if (all_closed) begin
      open_vld <= '0;
    end else begin
      if (bank_closed) open_vld[closed_bank] <= 1'b0;
      if (row_opened)  open_vld[opened_bank] <= 1'b1;
    end
  end

  always_ff @(posedge clk_n) begin
    if (row_opened) open_row[opened_bank] <= opened_row;
  end

  // follows the table live, so a refresh before the take is seen
  always_comb begin
    if (!open_vld[acc_bank])                acc_class = ddr_cmd_pkg::RC_EMPTY;
    else if (open_row[acc_bank] == acc_row) acc_class = ddr_cmd_pkg::RC_HIT;
    else                                    acc_class = ddr_cmd_pkg::RC_MISS;
  end

endmodule

/* ddr_geom_pkg.sv */
package ddr_geom_pkg;

  localparam int USER_ADDR_W = 26;
  localparam int BANK_W      = 3;
  localparam int ROW_W       = 14; // also the pin address width
  localparam int COL_W       = 9;  // word column
  localparam int NUM_BANKS   = 8;

  localparam int DQ_W        = 16;
  localparam int USER_DATA_W = 32;
  localparam int BE_W        = USER_DATA_W / 8;

  // user address {bank, row, word column}
  localparam int COL_LSB  = 0;
  localparam int ROW_LSB  = COL_LSB + COL_W;
  localparam int BANK_LSB = ROW_LSB + ROW_W;

  localparam int AP_BIT = 10; // all banks on precharge, low on read/write

endpackage

/* ddr_cmd_pkg.sv */
package ddr_cmd_pkg;

  // active-low {ras, cas, we}
  typedef enum logic [2:0] {
    CMD_LOAD_MODE = 3'b000,
    CMD_REFRESH   = 3'b001,
    CMD_PRECHARGE = 3'b010,
    CMD_ACTIVE    = 3'b011,
    CMD_WRITE     = 3'b100,
    CMD_READ      = 3'b101,
    CMD_NOP       = 3'b111
  } mem_cmd_e;

  typedef enum logic [3:0] {
    ST_INIT_WAIT,
    ST_INIT_PRE,
    ST_INIT_MODE,
    ST_INIT_REF,
    ST_IDLE,
    ST_PRE,
    ST_ACT,
    ST_RW,
    ST_REF_PRE,
    ST_REF
  } seq_state_e;

  typedef enum logic [1:0] {
    RC_HIT,
    RC_MISS,
    RC_EMPTY
  } row_class_e;

  localparam int DEF_T_RCD       = 2;
  localparam int DEF_T_RP        = 2;
  localparam int DEF_T_RFC       = 8;
  localparam int DEF_T_MRD       = 2;
  localparam int DEF_CAS_LAT     = 3;
  localparam int DEF_INIT_CYCLES = 50; // cke low after reset

endpackage
